// File: core_backend.f
hw/fetch_types.sv
hw/reg_file.sv
hw/inst_queue.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/core_backend.sv
sim/tb_core_backend.sv

// File: hw/core_backend.sv
`timescale 1ns/1ps

module core_backend
    import fetch_types::*;
(
    input  logic              clk,
    input  logic              rst,

    input  fetch_packet_t     in_packet,
    input  logic              in_valid,
    output logic              in_ready,

    output result_t           result,
    output logic              result_valid,

    output logic [QCNT_W-1:0] queue_count
);

    fetch_packet_t        q_packet;
    logic                 q_valid;
    logic                 q_ready;

    logic [REG_IDX_W-1:0] rd_addr_a;
    logic [REG_IDX_W-1:0] rd_addr_b;
    logic [XLEN-1:0]      rd_data_a;
    logic [XLEN-1:0]      rd_data_b;

    decoded_t             dec;
    logic                 dec_valid;
    exec_t                ex;
    logic                 ex_valid;

    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_addr;
    logic [XLEN-1:0]      wr_data;

    inst_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .in_packet  (in_packet),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_packet (q_packet),
        .out_valid  (q_valid),
        .out_ready  (q_ready),
        .count      (queue_count)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst       (rst),
        .q_packet  (q_packet),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wb_en     (wr_en),
        .wb_addr   (wr_addr),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    reg_file u_regs (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    execute_stage u_execute (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .dec_valid (dec_valid),
        .ex        (ex),
        .ex_valid  (ex_valid)
    );

    result_stage u_result (
        .clk          (clk),
        .rst          (rst),
        .ex           (ex),
        .ex_valid     (ex_valid),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import fetch_types::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  fetch_packet_t        q_packet,
    input  logic                 q_valid,
    output logic                 q_ready,

    output logic [REG_IDX_W-1:0] rd_addr_a,
    output logic [REG_IDX_W-1:0] rd_addr_b,
    input  logic [XLEN-1:0]      rd_data_a,
    input  logic [XLEN-1:0]      rd_data_b,

    input  logic                 wb_en,
    input  logic [REG_IDX_W-1:0] wb_addr,

    output decoded_t             dec,
    output logic                 dec_valid
);

    instr_t              instr;
    alu_op_e             alu_op;
    logic                wb;
    logic                uses_rs1;
    logic                uses_rs2;
    logic                is_imm;
    logic [XLEN-1:0]     imm_ext;
    logic [NUM_REGS-1:0] scoreboard;
    logic [NUM_REGS-1:0] sb_next;
    logic                hazard;
    logic                take;

    assign instr = q_packet.instr;

    always_comb begin
        alu_op   = ALU_NONE;
        wb       = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        is_imm   = 1'b0;
        case (instr.r_fmt.opcode)
            OP_ADD:  begin alu_op = ALU_ADD; wb = 1'b1; uses_rs1 = 1'b1; uses_rs2 = 1'b1; end
            OP_SUB:  begin alu_op = ALU_SUB; wb = 1'b1; uses_rs1 = 1'b1; uses_rs2 = 1'b1; end
            OP_AND:  begin alu_op = ALU_AND; wb = 1'b1; uses_rs1 = 1'b1; uses_rs2 = 1'b1; end
            OP_OR:   begin alu_op = ALU_OR;  wb = 1'b1; uses_rs1 = 1'b1; uses_rs2 = 1'b1; end
            OP_XOR:  begin alu_op = ALU_XOR; wb = 1'b1; uses_rs1 = 1'b1; uses_rs2 = 1'b1; end
            OP_SHL:  begin alu_op = ALU_SHL; wb = 1'b1; uses_rs1 = 1'b1; uses_rs2 = 1'b1; end
            OP_SHR:  begin alu_op = ALU_SHR; wb = 1'b1; uses_rs1 = 1'b1; uses_rs2 = 1'b1; end
            OP_ADDI: begin alu_op = ALU_ADD; wb = 1'b1; uses_rs1 = 1'b1; is_imm = 1'b1; end
            OP_ANDI: begin alu_op = ALU_AND; wb = 1'b1; uses_rs1 = 1'b1; is_imm = 1'b1; end
            OP_ORI:  begin alu_op = ALU_OR;  wb = 1'b1; uses_rs1 = 1'b1; is_imm = 1'b1; end
            default: begin alu_op = ALU_NONE; end
        endcase
    end

    assign imm_ext   = {{(XLEN-20){instr.i_fmt.imm[19]}}, instr.i_fmt.imm};
    assign rd_addr_a = instr.r_fmt.rs1;
    assign rd_addr_b = instr.r_fmt.rs2;

    // Hold on a pending source, and on a pending destination so that an
    // older write cannot release the bit of a younger one
    assign hazard = (uses_rs1 && scoreboard[instr.r_fmt.rs1]) ||
                    (uses_rs2 && scoreboard[instr.r_fmt.rs2]) ||
                    (wb && scoreboard[instr.r_fmt.rd]);

    assign q_ready = !hazard;
    assign take    = q_valid && q_ready;

    always_comb begin
        sb_next = scoreboard;
        if (wb_en) begin
            sb_next[wb_addr] = 1'b0;
        end
        if (take && wb) begin
            sb_next[instr.r_fmt.rd] = 1'b1;
        end
        sb_next[0] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scoreboard <= '0;
            dec_valid  <= 1'b0;
        end else begin
            scoreboard <= sb_next;
            dec_valid  <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dec.pc     <= q_packet.pc;
            dec.alu_op <= alu_op;
            dec.rd     <= instr.r_fmt.rd;
            dec.op_a   <= rd_data_a;
            dec.op_b   <= is_imm ? imm_ext : rd_data_b;
            dec.wb     <= wb;
        end
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import fetch_types::*;
(
    input  logic     clk,
    input  logic     rst,

    input  decoded_t dec,
    input  logic     dec_valid,

    output exec_t    ex,
    output logic     ex_valid
);

    logic [XLEN-1:0] alu_value;
    logic [4:0]      shamt;

    assign shamt = dec.op_b[4:0];

    // ###################################################################
    // ALU
    // ###################################################################

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_value = dec.op_a + dec.op_b;
            ALU_SUB:  alu_value = dec.op_a - dec.op_b;
            ALU_AND:  alu_value = dec.op_a & dec.op_b;
            ALU_OR:   alu_value = dec.op_a | dec.op_b;
            ALU_XOR:  alu_value = dec.op_a ^ dec.op_b;
            ALU_SHL:  alu_value = dec.op_a << shamt;
            ALU_SHR:  alu_value = dec.op_a >> shamt;
            default:  alu_value = '0;
        endcase
    end

    // ###################################################################
    // Output register
    // ###################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex.pc    <= dec.pc;
            ex.rd    <= dec.rd;
            ex.value <= alu_value;
            ex.wb    <= dec.wb;
        end
    end

endmodule

// File: hw/fetch_types.sv
package fetch_types;

    // ###################################################################
    // Sizes
    // ###################################################################

    localparam int QUEUE_DEPTH = 16;
    localparam int QADDR_W     = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);
    localparam int XLEN        = 32;
    localparam int NUM_REGS    = 16;
    localparam int REG_IDX_W   = 4;
    localparam int OPC_W       = 4;

    // ###################################################################
    // Opcodes
    // ###################################################################

    localparam logic [OPC_W-1:0] OP_NOP  = 4'h0;

    // Register-register forms
    localparam logic [OPC_W-1:0] OP_ADD  = 4'h1;
    localparam logic [OPC_W-1:0] OP_SUB  = 4'h2;
    localparam logic [OPC_W-1:0] OP_AND  = 4'h3;
    localparam logic [OPC_W-1:0] OP_OR   = 4'h4;
    localparam logic [OPC_W-1:0] OP_XOR  = 4'h5;
    localparam logic [OPC_W-1:0] OP_SHL  = 4'h6;
    localparam logic [OPC_W-1:0] OP_SHR  = 4'h7;

    // Register-immediate forms, 20-bit signed immediate
    localparam logic [OPC_W-1:0] OP_ADDI = 4'h8;
    localparam logic [OPC_W-1:0] OP_ANDI = 4'h9;
    localparam logic [OPC_W-1:0] OP_ORI  = 4'hA;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR
    } alu_op_e;

    // ###################################################################
    // Instruction word and stage records
    // ###################################################################

    typedef struct packed {
        logic [OPC_W-1:0]     opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [15:0]          unused;
    } r_fmt_t;

    typedef struct packed {
        logic [OPC_W-1:0]     opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic signed [19:0]   imm;
    } i_fmt_t;

    // Opcode, rd and rs1 sit in the same bits in both views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_t          instr;
    } fetch_packet_t;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        alu_op_e              alu_op;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      op_a;
        logic [XLEN-1:0]      op_b;
        logic                 wb;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      value;
        logic                 wb;
    } exec_t;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      value;
        logic                 wb;
    } result_t;

endpackage

// File: hw/inst_queue.sv
`timescale 1ns/1ps

module inst_queue
    import fetch_types::*;
(
    input  logic              clk,
    input  logic              rst,

    input  fetch_packet_t     in_packet,
    input  logic              in_valid,
    output logic              in_ready,

    output fetch_packet_t     out_packet,
    output logic              out_valid,
    input  logic              out_ready,

    output logic [QCNT_W-1:0] count
);

    fetch_packet_t      mem [QUEUE_DEPTH];

    // Pointers carry one extra wrap bit above the entry address
    logic [QADDR_W:0]   wr_ptr;
    logic [QADDR_W:0]   rd_ptr;
    logic [QADDR_W-1:0] wr_addr;
    logic [QADDR_W-1:0] rd_addr;
    logic               wr_flag;
    logic               rd_flag;

    logic               full;
    logic               empty;
    logic               enq;
    logic               deq;
    logic [QCNT_W-1:0]  count_next;

    assign {wr_flag, wr_addr} = wr_ptr;
    assign {rd_flag, rd_addr} = rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_addr == rd_addr) && (wr_flag != rd_flag);

    assign enq = in_valid && !full;
    assign deq = out_ready && !empty;

    assign in_ready   = !full && !rst;
    assign out_valid  = !empty;
    assign out_packet = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            mem[wr_addr] <= in_packet;
        end
    end

    // ###################################################################
    // Occupancy
    // ###################################################################

    always_comb begin
        count_next = count;
        case ({enq, deq})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import fetch_types::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic [REG_IDX_W-1:0] rd_addr_a,
    input  logic [REG_IDX_W-1:0] rd_addr_b,
    output logic [XLEN-1:0]      rd_data_a,
    output logic [XLEN-1:0]      rd_data_b,

    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_addr,
    input  logic [XLEN-1:0]      wr_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Register 0 is never written, so it always reads as zero
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// File: hw/result_stage.sv
`timescale 1ns/1ps

module result_stage
    import fetch_types::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  exec_t                ex,
    input  logic                 ex_valid,

    output logic                 wr_en,
    output logic [REG_IDX_W-1:0] wr_addr,
    output logic [XLEN-1:0]      wr_data,

    output result_t              result,
    output logic                 result_valid
);

    // The write lands on the same edge that raises result_valid
    assign wr_en   = ex_valid && ex.wb;
    assign wr_addr = ex.rd;
    assign wr_data = ex.value;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            result.pc    <= ex.pc;
            result.rd    <= ex.rd;
            result.value <= ex.value;
            result.wb    <= ex.wb;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the core_backend testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_core_backend -f core_backend.f \
    -Mdir obj_dir -o tb_core_backend > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_core_backend > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log \
    && { echo "Simulation result: FAIL"; exit 1; } \
    || { echo "Simulation result: PASS"; exit 0; }

// File: sim/core_backend_input.txt
# test pc instr rd value wb, all but the test number in hex
# value and wb are the expected result record for that instruction
1 00000100 81000123 1 00000123 1
1 00000104 82000F0F 2 00000F0F 1
1 00000108 83000004 3 00000004 1
1 0000010C 14120000 4 00001032 1
1 00000110 25120000 5 FFFFF214 1
1 00000114 36120000 6 00000103 1
1 00000118 47120000 7 00000F2F 1
1 0000011C 58120000 8 00000E2C 1
1 00000120 69130000 9 00001230 1
1 00000124 7A230000 A 000000F0 1
2 00000128 8B0FFFFB B FFFFFFFB 1
2 0000012C 9CB0FF0F C 0000FF0B 1
2 00000130 AD180000 D FFF80123 1
2 00000134 9E2FFFF0 E 00000F00 1
3 00000138 81100001 1 00000124 1
3 0000013C 11110000 1 00000248 1
3 00000140 22130000 2 00000244 1
3 00000144 51210000 1 0000000C 1
3 00000148 6F130000 F 000000C0 1
4 0000014C 8000007F 0 0000007F 1
4 00000150 15000000 5 00000000 1
4 00000154 F6120000 6 00000000 0
4 00000158 47600000 7 00000103 1
4 0000015C 00000000 0 00000000 0
5 00000160 844FFFCE 4 00001000 1
5 00000164 79430000 9 00000100 1
5 00000168 1A9A0000 A 000001F0 1
5 0000016C 9BA000F0 B 000000F0 1
5 00000170 ACB00005 C 000000F5 1
5 00000174 2DC90000 D FFFFFFF5 1

// File: sim/tb_core_backend.sv
`timescale 1ns/1ps

module tb_core_backend
    import fetch_types::*;
();

    localparam int MAX_LINES       = 96;
    localparam int FILL_LEN        = 32;
    localparam int CYCLES_PER_LINE = 40;
    localparam int RESET_CYCLES    = 10;

    logic              clk;
    logic              rst;
    fetch_packet_t     in_packet;
    logic              in_valid;
    logic              in_ready;
    result_t           result;
    logic              result_valid;
    logic [QCNT_W-1:0] queue_count;

    // One row per instruction, in program order
    int          t_num   [MAX_LINES];
    logic [31:0] t_pc    [MAX_LINES];
    logic [31:0] t_instr [MAX_LINES];
    logic [3:0]  t_rd    [MAX_LINES];
    logic [31:0] t_value [MAX_LINES];
    logic        t_wb    [MAX_LINES];

    int     n_lines      = 0;
    int     file_lines   = 0;
    logic   load_done    = 1'b0;
    int     load_err     = 0;
    int     rec_idx      = 0;
    int     err_count    = 0;
    int     test_err     = 0;
    int     test_recs    = 0;
    int     tests_run    = 0;
    int     tests_bad    = 0;
    int     full_edges   = 0;
    logic   first_accept = 1'b0;
    integer seed;

    core_backend u_dut (
        .clk          (clk),
        .rst          (rst),
        .in_packet    (in_packet),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .result       (result),
        .result_valid (result_valid),
        .queue_count  (queue_count)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ####################################################################
    // Vector loading
    // ####################################################################

    task automatic load_vectors();
        int          fd;
        int          code;
        int          tn;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [3:0]  rd;
        logic [31:0] value;
        logic        wb;
        string       line;
        fd = $fopen("sim/core_backend_input.txt", "r");
        if (fd == 0) begin
            $display("Input file sim/core_backend_input.txt could not be opened");
            load_err++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES - FILL_LEN) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    code = $sscanf(line, "%d %h %h %h %h %h", tn, pc, instr, rd, value, wb);
                    if (code == 6) begin
                        t_num[n_lines]   = tn;
                        t_pc[n_lines]    = pc;
                        t_instr[n_lines] = instr;
                        t_rd[n_lines]    = rd;
                        t_value[n_lines] = value;
                        t_wb[n_lines]    = wb;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                $display("No instruction lines were found in the input file");
                load_err++;
            end
        end
    endtask

    // A chain of ADDI on r1 drains one entry every three cycles, so
    // pushing it without gaps fills the queue
    task automatic append_fill_chain();
        logic [31:0] base_pc;
        base_pc = t_pc[n_lines - 1];
        for (int k = 0; k < FILL_LEN; k++) begin
            t_num[n_lines] = 5;
            t_pc[n_lines]  = base_pc + 32'(4 * (k + 1));
            if (k == 0) begin
                t_instr[n_lines] = {OP_ADDI, 4'd1, 4'd0, 20'h00100};
            end else begin
                t_instr[n_lines] = {OP_ADDI, 4'd1, 4'd1, 20'h00001};
            end
            t_rd[n_lines]    = 4'd1;
            t_value[n_lines] = 32'h0000_0100 + 32'(k);
            t_wb[n_lines]    = 1'b1;
            n_lines++;
        end
    endtask

    task automatic check_record(input int idx);
        if (result.pc !== t_pc[idx]) begin
            $display("FAILED at %0t: result.pc expected %h got %h", $time, t_pc[idx], result.pc);
            test_err++;
        end
        if (result.rd !== t_rd[idx]) begin
            $display("FAILED at %0t: result.rd expected %h got %h", $time, t_rd[idx], result.rd);
            test_err++;
        end
        if (result.value !== t_value[idx]) begin
            $display("FAILED at %0t: result.value expected %h got %h",
                     $time, t_value[idx], result.value);
            test_err++;
        end
        if (result.wb !== t_wb[idx]) begin
            $display("FAILED at %0t: result.wb expected %b got %b", $time, t_wb[idx], result.wb);
            test_err++;
        end
    endtask

    task automatic report_test(input int num, input int recs, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d: %0d records, PASS", num, recs);
        end else begin
            tests_bad++;
            $display("Test %0d: %0d records, %0d mismatches, FAIL", num, recs, errs);
        end
    endtask

    // ####################################################################
    // Monitor
    // ####################################################################

    always @(posedge clk) begin
        if (!rst) begin
            if (int'(queue_count) == QUEUE_DEPTH) begin
                full_edges++;
            end
            if (int'(queue_count) > QUEUE_DEPTH) begin
                $display("FAILED at %0t: queue_count expected at most %0d got %0d",
                         $time, QUEUE_DEPTH, queue_count);
                err_count++;
            end
            if (int'(queue_count) == QUEUE_DEPTH && in_ready) begin
                $display("FAILED at %0t: in_ready expected 0 got %b", $time, in_ready);
                err_count++;
            end

            // Idle state between reset and the first accepted packet
            if (!first_accept) begin
                if (result_valid !== 1'b0) begin
                    $display("FAILED at %0t: result_valid expected 0 got %b", $time, result_valid);
                    test_err++;
                end
                if (queue_count !== '0) begin
                    $display("FAILED at %0t: queue_count expected 0 got %0d", $time, queue_count);
                    test_err++;
                end
                if (in_valid && in_ready) begin
                    first_accept = 1'b1;
                    err_count    = err_count + test_err;
                    report_test(6, 0, test_err);
                    test_err = 0;
                end
            end

            if (result_valid) begin
                if (rec_idx >= n_lines) begin
                    $display("An extra result record with pc %h arrived at %0t", result.pc, $time);
                    err_count++;
                end else begin
                    check_record(rec_idx);
                    test_recs++;
                    if (rec_idx == n_lines - 1 || t_num[rec_idx + 1] != t_num[rec_idx]) begin
                        err_count = err_count + test_err;
                        report_test(t_num[rec_idx], test_recs, test_err);
                        test_recs = 0;
                        test_err  = 0;
                    end
                    rec_idx++;
                end
            end
        end
    end

    // ####################################################################
    // Stimulus
    // ####################################################################

    initial begin
        seed      = 60853;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_packet = '0;
        load_vectors();
        file_lines = n_lines;
        if (n_lines > 0) begin
            append_fill_chain();
        end
        load_done = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);

        for (int i = 0; i < n_lines; i++) begin
            if (i < file_lines && ($random(seed) & 3) == 0) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            while (!in_ready) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_packet.pc    = t_pc[i];
            in_packet.instr = t_instr[i];
            in_valid        = 1'b1;
            @(negedge clk);
        end
        in_valid = 1'b0;

        wait (rec_idx == n_lines);
        // A few spare cycles catch any duplicated record
        repeat (8) @(posedge clk);
        if (full_edges == 0) begin
            $display("The queue never filled up, so in_ready was never seen at a full queue");
            err_count++;
        end
        $display("Tests %0d, with errors %0d, records %0d of %0d, full edges %0d, errors %0d",
                 tests_run, tests_bad, rec_idx, n_lines, full_edges, err_count + load_err);
        if (err_count + load_err == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (load_done);
        repeat (RESET_CYCLES + CYCLES_PER_LINE * n_lines) @(posedge clk);
        $display("Timeout: only %0d of %0d result records arrived in time", rec_idx, n_lines);
        $display("Checks failed");
        $finish;
    end

endmodule
